// ==== verilog/phase_pkg.sv ====
`default_nettype none

package phase_pkg;

   // delay line taps
   localparam int TAP_W = 9;
   typedef logic [TAP_W-1:0] tap_t;
   localparam tap_t MAX_TAP = tap_t'(511);

   // sample timing after a tap load
   localparam int SETTLE_CYCLES = 8;
   localparam int SYNC_STAGES = 3;
   localparam int SAMPLE_LATENCY = SETTLE_CYCLES + SYNC_STAGES;
   localparam int WAIT_W = $clog2(SAMPLE_LATENCY);
   typedef logic [WAIT_W-1:0] wait_cnt_t;

   // narrower phases are not reported
   localparam tap_t MIN_PHASE_WIDTH = tap_t'(16);

   typedef logic [15:0] print_addr_t;
   typedef logic [63:0] print_data_t;
   typedef logic [7:0] drop_count_t;

   localparam print_addr_t MSG_ADDR_PHASE = 16'd80;
   localparam print_addr_t MSG_ADDR_ABORT = 16'd81;
   localparam logic [31:0] MSG_TAG = 32'h2020_2087;

   // print word, msb first
   typedef struct packed {
      logic [31:0] tag;
      logic [6:0]  pad_hi;
      tap_t        initial_delay;
      logic [2:0]  pad_mid;
      tap_t        width;
      logic        pad_lo;
      logic        initial_value;
      logic        abort;
      logic        one;
   } print_word_t;

endpackage

`default_nettype wire

// ==== verilog/delay_tap_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface delay_tap_if;
   import phase_pkg::*;

   logic load;
   tap_t value;
   logic sample;
   logic sample_valid;

   modport engine (
      output load, value,
      input  sample, sample_valid
   );

   modport sampler (
      input  load, value,
      output sample, sample_valid
   );
endinterface

`default_nettype wire

// ==== verilog/phase_result_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface phase_result_if;
   import phase_pkg::*;

   logic valid;
   logic initial_value;
   logic abort;
   tap_t width;
   tap_t initial_delay;

   // valid is a one cycle pulse
   modport source (
      output valid, initial_value, abort, width, initial_delay
   );

   modport sink (
      input valid, initial_value, abort, width, initial_delay
   );
endinterface

`default_nettype wire

// ==== verilog/phase_sync_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_sync_sampler (
   input  logic            cpm_clk,
   input  logic            rst_n,
   input  logic            delay_sample,
   output logic            delay_load,
   output phase_pkg::tap_t delay_value,
   delay_tap_if.sampler    taps
);
   import phase_pkg::*;

   wait_cnt_t              wait_cnt;
   logic [SYNC_STAGES-1:0] sync_q;
   logic                   sample_valid_q;

   // tap load out to the delay line
   always_ff @(posedge cpm_clk) begin
      if (!rst_n) begin
         delay_load <= 1'b0;
      end else begin
         delay_load <= taps.load;
      end
   end

   always_ff @(posedge cpm_clk) begin
      if (taps.load) begin
         delay_value <= taps.value;
      end
   end

   // settle time plus synchronizer depth
   always_ff @(posedge cpm_clk) begin
      if (!rst_n) begin
         wait_cnt <= '0;
         sample_valid_q <= 1'b0;
      end else begin
         sample_valid_q <= (wait_cnt == wait_cnt_t'(1));
         if (taps.load) begin
            wait_cnt <= wait_cnt_t'(SAMPLE_LATENCY - 1);
         end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
         end
      end
   end

   // async sample into cpm_clk
   always_ff @(posedge cpm_clk) begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], delay_sample};
   end

   assign taps.sample = sync_q[SYNC_STAGES-1];
   assign taps.sample_valid = sample_valid_q;

endmodule

`default_nettype wire

// ==== verilog/phase_measure.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_measure (
   input  logic           cpm_clk,
   input  logic           rst_n,
   delay_tap_if.engine    taps,
   phase_result_if.source result
);
   import phase_pkg::*;

   typedef enum logic [1:0] {ST_LOAD, ST_WAIT, ST_DONE} state_t;
   typedef enum logic [1:0] {SRCH_INIT, SRCH_FIRST, SRCH_SECOND} search_t;

   state_t  state;
   search_t search;
   tap_t    tap;
   logic    initial_value;
   logic    abort;
   tap_t    width;
   tap_t    initial_delay;
   logic    at_end;
   logic    changed;
   logic    step;

   assign at_end = (tap == MAX_TAP);
   assign changed = (taps.sample != initial_value);
   assign step = (state == ST_WAIT) && taps.sample_valid;

   always_ff @(posedge cpm_clk) begin
      if (!rst_n) begin
         state <= ST_LOAD;
         search <= SRCH_INIT;
         tap <= '0;
      end else begin
         case (state)
            ST_LOAD: state <= ST_WAIT;
            ST_WAIT: begin
               if (taps.sample_valid) begin
                  state <= ST_LOAD;
                  tap <= tap + 1'b1;
                  case (search)
                     SRCH_INIT: search <= SRCH_FIRST;
                     SRCH_FIRST: begin
                        if (changed) begin
                           search <= SRCH_SECOND;
                        end else if (at_end) begin
                           state <= ST_DONE;
                        end
                     end
                     SRCH_SECOND: begin
                        if (!changed || at_end) begin
                           state <= ST_DONE;
                        end
                     end
                     default: search <= SRCH_INIT;
                  endcase
               end
            end
            ST_DONE: begin
               // restart sweep from tap 0
               state <= ST_LOAD;
               search <= SRCH_INIT;
               tap <= '0;
            end
            default: state <= ST_LOAD;
         endcase
      end
   end

   always_ff @(posedge cpm_clk) begin
      if (step) begin
         case (search)
            SRCH_INIT: initial_value <= taps.sample;
            SRCH_FIRST: begin
               if (changed) begin
                  initial_delay <= tap;
               end else if (at_end) begin
                  // no edge found at all
                  abort <= 1'b1;
                  width <= '0;
                  initial_delay <= tap;
               end
            end
            SRCH_SECOND: begin
               if (!changed) begin
                  abort <= 1'b0;
                  width <= tap - initial_delay;
               end else if (at_end) begin
                  abort <= 1'b1;
                  width <= '0;
               end
            end
            default: ;
         endcase
      end
   end

   assign taps.load = (state == ST_LOAD);
   assign taps.value = tap;

   assign result.valid = (state == ST_DONE);
   assign result.initial_value = initial_value;
   assign result.abort = abort;
   assign result.width = width;
   assign result.initial_delay = initial_delay;

endmodule

`default_nettype wire

// ==== verilog/dprintf_format.sv ====
`timescale 1ns/1ns
`default_nettype none

module dprintf_format (
   phase_result_if.sink          result,
   output logic                  msg_valid,
   output phase_pkg::print_addr_t msg_address,
   output phase_pkg::print_data_t msg_data
);
   import phase_pkg::*;

   print_word_t word;
   logic        wide_enough;

   // only phases wider than the minimum are worth a print
   assign wide_enough = (result.width > MIN_PHASE_WIDTH);

   assign msg_valid = result.valid && (result.abort || wide_enough);

   assign msg_address = result.abort ? MSG_ADDR_ABORT : MSG_ADDR_PHASE;

   always_comb begin
      word.tag = MSG_TAG;
      word.pad_hi = '0;
      word.initial_delay = result.initial_delay;
      word.pad_mid = '0;
      word.width = result.width;
      word.pad_lo = 1'b0;
      word.initial_value = result.initial_value;
      word.abort = result.abort;
      word.one = 1'b1;
   end

   assign msg_data = print_data_t'(word);

endmodule

`default_nettype wire

// ==== verilog/dprintf_req_hold.sv ====
`timescale 1ns/1ns
`default_nettype none

module dprintf_req_hold (
   input  logic                   cpm_clk,
   input  logic                   rst_n,
   input  logic                   msg_valid,
   input  phase_pkg::print_addr_t msg_address,
   input  phase_pkg::print_data_t msg_data,
   input  logic                   req_ack,
   output logic                   req_valid,
   output phase_pkg::print_addr_t req_address,
   output phase_pkg::print_data_t req_data,
   output phase_pkg::drop_count_t dropped_count
);

   logic capture;

   assign capture = msg_valid && !req_valid;

   always_ff @(posedge cpm_clk) begin
      if (!rst_n) begin
         req_valid <= 1'b0;
         dropped_count <= '0;
      end else begin
         if (req_valid) begin
            if (req_ack) begin
               req_valid <= 1'b0;
            end
            // still busy, message is lost
            if (msg_valid && !(&dropped_count)) begin
               dropped_count <= dropped_count + 1'b1;
            end
         end else if (msg_valid) begin
            req_valid <= 1'b1;
         end
      end
   end

   // held until acked
   always_ff @(posedge cpm_clk) begin
      if (capture) begin
         req_address <= msg_address;
         req_data <= msg_data;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/phase_debug_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module phase_debug_top (
   input  logic                   cpm_clk,
   input  logic                   rst_n,
   input  logic                   delay_sample,
   input  logic                   req_ack,
   output logic                   delay_load,
   output phase_pkg::tap_t        delay_value,
   output logic                   req_valid,
   output phase_pkg::print_addr_t req_address,
   output phase_pkg::print_data_t req_data,
   output phase_pkg::drop_count_t dropped_count
);
   import phase_pkg::*;

   delay_tap_if    taps ();
   phase_result_if result ();

   logic        msg_valid;
   print_addr_t msg_address;
   print_data_t msg_data;

   phase_sync_sampler sampler0 (
      .cpm_clk      (cpm_clk),
      .rst_n        (rst_n),
      .delay_sample (delay_sample),
      .delay_load   (delay_load),
      .delay_value  (delay_value),
      .taps         (taps)
   );

   phase_measure measure0 (
      .cpm_clk (cpm_clk),
      .rst_n   (rst_n),
      .taps    (taps),
      .result  (result)
   );

   dprintf_format format0 (
      .result      (result),
      .msg_valid   (msg_valid),
      .msg_address (msg_address),
      .msg_data    (msg_data)
   );

   dprintf_req_hold hold0 (
      .cpm_clk       (cpm_clk),
      .rst_n         (rst_n),
      .msg_valid     (msg_valid),
      .msg_address   (msg_address),
      .msg_data      (msg_data),
      .req_ack       (req_ack),
      .req_valid     (req_valid),
      .req_address   (req_address),
      .req_data      (req_data),
      .dropped_count (dropped_count)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_delay_line_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_delay_line_model (
   input  phase_pkg::tap_t delay_value,
   input  int              period,
   input  int              high_time,
   input  int              offset,
   output logic            delay_sample
);

   // clock seen through the delay line at the loaded tap
   always_comb begin
      if (period == 0) begin
         delay_sample = 1'b0;
      end else begin
         delay_sample = ((int'(delay_value) + offset) % period) < high_time;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_phase_debug.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_phase_debug;
   import phase_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int N_SCEN = 5;
   localparam int TIMEOUT_CYCLES = N_SCEN * 2 * int'(MAX_TAP) * (SAMPLE_LATENCY + 1);

   logic        cpm_clk;
   logic        rst_n;
   logic        delay_sample;
   logic        req_ack;
   logic        delay_load;
   tap_t        delay_value;
   logic        req_valid;
   print_addr_t req_address;
   print_data_t req_data;
   drop_count_t dropped_count;

   int period;
   int high_time;
   int offset;
   int seed = 79828;
   logic ack_en;

   int errors_main;
   int errors_hs;
   int errors_step;
   int errors_load;
   int errors_value;
   int checks;
   int req_count;
   int load_gap;

   phase_debug_top dut0 (
      .cpm_clk       (cpm_clk),
      .rst_n         (rst_n),
      .delay_sample  (delay_sample),
      .req_ack       (req_ack),
      .delay_load    (delay_load),
      .delay_value   (delay_value),
      .req_valid     (req_valid),
      .req_address   (req_address),
      .req_data      (req_data),
      .dropped_count (dropped_count)
   );

   tb_delay_line_model line0 (
      .delay_value  (delay_value),
      .period       (period),
      .high_time    (high_time),
      .offset       (offset),
      .delay_sample (delay_sample)
   );

   initial begin
      cpm_clk = 1'b0;
      forever #(CLK_PERIOD / 2) cpm_clk = ~cpm_clk;
   end

   task automatic show_mismatch(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
   endtask

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      assert (exp == act) else begin
         errors_main++;
         show_mismatch(name, exp, act);
      end
   endtask

   // print word layout, msb first
   function automatic logic [63:0] expected_word(input tap_t idly, input tap_t wid,
                                                 input logic ival, input logic ab);
      return {32'h2020_2087, 7'd0, idly, 3'd0, wid, 1'b0, ival, ab, 1'b1};
   endfunction

   // reset, new line settings, reset state
   task automatic start_scenario(input int p, input int h, input int o);
      @(posedge cpm_clk);
      rst_n <= 1'b0;
      period <= p;
      high_time <= h;
      offset <= o;
      @(posedge cpm_clk);
      @(negedge cpm_clk);
      check_value("delay_load", 64'(1'b0), 64'(delay_load));
      check_value("req_valid", 64'(1'b0), 64'(req_valid));
      check_value("dropped_count", 64'(8'd0), 64'(dropped_count));
      @(posedge cpm_clk);
      rst_n <= 1'b1;
   endtask

   task automatic wait_request();
      do begin
         @(negedge cpm_clk);
      end while (!req_valid);
   endtask

   task automatic wait_release();
      do begin
         @(negedge cpm_clk);
      end while (req_valid);
   endtask

   // a load of tap 0 starts each sweep
   task automatic wait_sweeps(input int n);
      int seen;
      seen = 0;
      while (seen < n) begin
         @(negedge cpm_clk);
         if (delay_load && delay_value == '0) begin
            seen++;
         end
      end
   endtask

   initial begin
      int dly;
      forever begin
         @(posedge cpm_clk);
         if (ack_en && req_valid && !req_ack) begin
            dly = $unsigned($random(seed)) % 7;
            repeat (dly) @(posedge cpm_clk);
            req_ack <= 1'b1;
            @(posedge cpm_clk);
            req_ack <= 1'b0;
         end
      end
   end

   // cycles since the last tap load
   always @(posedge cpm_clk) begin
      if (!rst_n) begin
         load_gap <= SAMPLE_LATENCY;
      end else if (delay_load) begin
         load_gap <= 0;
      end else begin
         load_gap <= load_gap + 1;
      end
   end

   assert property (@(posedge cpm_clk) disable iff (!rst_n)
                    delay_load |-> load_gap >= SAMPLE_LATENCY)
   else begin
      errors_load++;
      $display("Failure at %0t ns: delay_load came again before the sample settled", $time);
   end

   assert property (@(posedge cpm_clk) disable iff (!rst_n)
                    !$stable(delay_value) |-> delay_load)
   else begin
      errors_value++;
      $display("Failure at %0t ns: delay_value changed without delay_load", $time);
   end

   // tap steps by one or restarts
   initial begin
      tap_t prev_tap;
      logic have_prev;
      have_prev = 1'b0;
      prev_tap = '0;
      forever begin
         @(negedge cpm_clk);
         if (!rst_n) begin
            have_prev = 1'b0;
         end else if (delay_load) begin
            if (have_prev) begin
               assert (delay_value == prev_tap + 1'b1 || delay_value == '0) else begin
                  errors_step++;
                  show_mismatch("delay_value", 64'(prev_tap + 1'b1), 64'(delay_value));
               end
            end
            prev_tap = delay_value;
            have_prev = 1'b1;
         end
      end
   end

   // request held until ack, dropped the cycle after
   initial begin
      logic        busy;
      logic        last_ack;
      logic        last_valid;
      print_addr_t last_addr;
      print_data_t last_data;
      busy = 1'b0;
      last_ack = 1'b0;
      last_valid = 1'b0;
      last_addr = '0;
      last_data = '0;
      req_count = 0;
      forever begin
         @(negedge cpm_clk);
         if (!rst_n) begin
            busy = 1'b0;
            last_valid = 1'b0;
            req_count = 0;
         end else begin
            if (req_valid && !last_valid) begin
               req_count++;
            end
            if (busy && last_ack) begin
               assert (!req_valid) else begin
                  errors_hs++;
                  show_mismatch("req_valid", 64'(1'b0), 64'(req_valid));
               end
            end else if (busy) begin
               assert (req_valid) else begin
                  errors_hs++;
                  show_mismatch("req_valid", 64'(1'b1), 64'(req_valid));
               end
               assert (req_address == last_addr) else begin
                  errors_hs++;
                  show_mismatch("req_address", 64'(last_addr), 64'(req_address));
               end
               assert (req_data == last_data) else begin
                  errors_hs++;
                  show_mismatch("req_data", last_data, req_data);
               end
            end
            busy = req_valid;
            last_valid = req_valid;
            last_ack = req_ack;
            last_addr = req_address;
            last_data = req_data;
         end
      end
   end

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("timeout: the run did not reach its end in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      int total;
      rst_n = 1'b0;
      req_ack = 1'b0;
      ack_en = 1'b0;
      period = 0;
      high_time = 0;
      offset = 0;
      errors_main = 0;
      errors_hs = 0;
      errors_step = 0;
      errors_load = 0;
      errors_value = 0;
      checks = 0;

      // phase of 40 taps starting at tap 10
      ack_en = 1'b1;
      start_scenario(200, 40, 190);
      wait_request();
      check_value("req_address", 64'(16'd80), 64'(req_address));
      check_value("req_data", expected_word(9'd10, 9'd40, 1'b0, 1'b0), req_data);
      // ack closes the request
      wait_release();

      // too narrow to report
      start_scenario(200, 10, 190);
      wait_sweeps(3);
      check_value("request count", 64'(0), 64'(req_count));

      // no edge at all
      start_scenario(0, 0, 0);
      wait_request();
      check_value("req_address", 64'(16'd81), 64'(req_address));
      check_value("req_data tag", 64'(32'h2020_2087), 64'(req_data[63:32]));
      check_value("req_data width", 64'(9'd0), 64'(req_data[12:4]));
      check_value("req_data abort", 64'(1'b1), 64'(req_data[1]));
      check_value("req_data one", 64'(1'b1), 64'(req_data[0]));

      // ack withheld, three measurements and one held
      ack_en = 1'b0;
      start_scenario(200, 40, 190);
      wait_sweeps(4);
      @(negedge cpm_clk);
      check_value("req_valid", 64'(1'b1), 64'(req_valid));
      check_value("dropped_count", 64'(8'd2), 64'(dropped_count));
      ack_en = 1'b1;
      start_scenario(200, 40, 190);
      @(negedge cpm_clk);
      check_value("dropped_count", 64'(8'd0), 64'(dropped_count));
      check_value("req_valid", 64'(1'b0), 64'(req_valid));

      total = errors_main + errors_hs + errors_step + errors_load + errors_value;
      $display("%0d checks, %0d errors (values %0d, handshake %0d, taps %0d, loads %0d, changes %0d)",
               checks, total, errors_main, errors_hs, errors_step, errors_load, errors_value);
      if (total == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/phase_pkg.sv
verilog/delay_tap_if.sv
verilog/phase_result_if.sv
verilog/phase_sync_sampler.sv
verilog/phase_measure.sv
verilog/dprintf_format.sv
verilog/dprintf_req_hold.sv
verilog/phase_debug_top.sv
testbench/tb_delay_line_model.sv
testbench/tb_phase_debug.sv

// ==== Makefile ====
TOP := tb_phase_debug

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
